/* cw305.f */
hdl/cw305_pkg.sv
hdl/usb_bus_fsm.sv
hdl/usb_reg_file.sv
hdl/trigger_timer.sv
hdl/cw305_top.sv
verification/cw305_checker.sv
verification/cw305_tb.sv

/* Bender.yml */
package:
  name: cw305

sources:
  - files:
      - hdl/cw305_pkg.sv
      - hdl/usb_bus_fsm.sv
      - hdl/usb_reg_file.sv
      - hdl/trigger_timer.sv
      - hdl/cw305_top.sv
  - target: test
    files:
      - verification/cw305_checker.sv
      - verification/cw305_tb.sv

/* verification/cw305_tb.sv */
// CW305 target testbench
`timescale 1ns/1ps
`default_nettype none

module cw305_tb;

    import cw305_pkg::*;

    typedef enum logic [2:0] {op_sw, op_wr, op_rd, op_fill, op_led, op_trig} op_t;

    typedef struct packed {
        op_t               op;
        logic [addr_w-1:0] addr;
        byte_t             data;      // Write data or switch pattern
        byte_t             exp_byte;  // Expected output region byte
    } entry_t;

    localparam int n_stim = 23;

    logic              usb_clk, rst;
    logic [addr_w-1:0] usb_addr;
    byte_t             usb_data_in, usb_data_out;
    logic              usb_data_oe, usb_rdn, usb_wrn, usb_cen, usb_trigger;
    logic              sw1, sw2, sw3, sw4, pushbutton, led1, led2, led3;
    logic              pll_clk1, tio_trigger, tio_clkout, tio_clkin;
    byte_t             shadow [16];            // Input region as the host sees it
    logic [31:0]       lfsr = 32'hbb3f_94f1;

    entry_t stim [n_stim] = '{
        '{op_rd,   21'h000, 8'h00, 8'h2E},  // ID byte
        '{op_rd,   21'h010, 8'h00, 8'h2E},  // Alias of ID
        '{op_rd,   21'h002, 8'h00, 8'h00},  // No pulses after reset
        '{op_led,  21'h000, 8'h00, 8'h00},
        '{op_sw,   21'h000, 8'h15, 8'h00},  // Pushbutton, sw3, sw1
        '{op_rd,   21'h001, 8'h00, 8'h15},
        '{op_sw,   21'h000, 8'h0A, 8'h00},
        '{op_rd,   21'h001, 8'h00, 8'h0A},
        '{op_fill, 21'h400, 8'h00, 8'h00},  // Random bytes over whole input region
        '{op_led,  21'h000, 8'h00, 8'h00},
        '{op_rd,   21'h412, 8'h00, 8'h00},  // Hits index 2
        '{op_wr,   21'h000, 8'h55, 8'h00},  // Ignored by the output region
        '{op_rd,   21'h000, 8'h00, 8'h2E},
        '{op_rd,   21'h400, 8'h00, 8'h00},  // Input byte 0 untouched
        '{op_wr,   21'h401, 8'h03, 8'h00},
        '{op_trig, 21'h000, 8'h00, 8'h00},
        '{op_rd,   21'h002, 8'h00, 8'h01},
        '{op_wr,   21'h401, 8'h07, 8'h00},
        '{op_trig, 21'h000, 8'h00, 8'h00},
        '{op_rd,   21'h002, 8'h00, 8'h02},
        '{op_wr,   21'h401, 8'h00, 8'h00},  // Zero length
        '{op_trig, 21'h000, 8'h00, 8'h00},
        '{op_rd,   21'h002, 8'h00, 8'h02}   // Count unchanged
    };

    cw305_top u_cw305_top (.*);

    initial begin
        usb_clk = 1'b0;
        forever #2 usb_clk = ~usb_clk;  // 4 ns period
    end

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_byte(output byte_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);  // One step per bit
            b    = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t want);
        if (got !== want) begin
            $display("MISMATCH time %0t: %s got %02h expected %02h", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("MISMATCH time %0t: %s got %b expected %b", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic bus_write(input logic [addr_w-1:0] a, input byte_t d);
        @(negedge usb_clk);
        usb_addr    = a;
        usb_data_in = d;
        usb_wrn     = 1'b0;
        repeat (2) @(negedge usb_clk);                 // wrn low across two edges
        check_bit("usb_data_oe", usb_data_oe, 1'b0);  // Pad must stay off
        usb_wrn = 1'b1;
        if (a[10]) begin
            shadow[a[3:0]] = d;  // Upper index bits alias
        end
    endtask

    task automatic bus_read(input logic [addr_w-1:0] a, output byte_t d);
        int n;
        @(negedge usb_clk);
        usb_addr = a;
        usb_rdn  = 1'b0;
        repeat (3) @(negedge usb_clk);
        check_bit("usb_data_oe", usb_data_oe, 1'b1);
        d       = usb_data_out;  // Sampled before release
        usb_rdn = 1'b1;
        n       = 0;
        while (usb_data_oe !== 1'b0) begin
            if (n == 4) begin
                $display("Timeout: usb_data_oe still high after rdn released");
                stop_run();
            end
            @(negedge usb_clk);
            n++;
        end
    endtask

    // One usb_trigger edge, then measure tio_trigger
    task automatic run_trigger();
        byte_t len;
        int    width;
        int    n;
        len   = shadow[1];  // Last value written to 0x401
        width = 0;
        n     = 0;
        @(negedge usb_clk);
        usb_trigger = 1'b1;
        while (len != 0 && tio_trigger !== 1'b1) begin
            if (n == 4) begin
                $display("Timeout: tio_trigger did not rise after usb_trigger edge");
                stop_run();
            end
            @(negedge usb_clk);
            n++;
        end
        while (tio_trigger === 1'b1) begin
            if (width == 300) begin
                $display("Timeout: tio_trigger did not fall");
                stop_run();
            end
            usb_trigger = (width != 1);  // Low, then a new rise mid-pulse
            width++;
            @(negedge usb_clk);
        end
        check_byte("tio_trigger width", byte_t'(width), len);
        repeat (6) begin
            @(negedge usb_clk);
            check_bit("tio_trigger", tio_trigger, 1'b0);  // No second pulse
        end
        usb_trigger = 1'b0;
    endtask

    initial begin
        entry_t e;
        byte_t  got;
        byte_t  want;
        rst         = 1'b1;
        usb_addr    = '0;
        usb_data_in = '0;
        usb_rdn     = 1'b1;
        usb_wrn     = 1'b1;
        usb_cen     = 1'b0;
        usb_trigger = 1'b0;
        {pushbutton, sw4, sw3, sw2, sw1} = 5'b0;
        pll_clk1    = 1'b0;
        tio_clkin   = 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge usb_clk);  // Four reset edges
        @(negedge usb_clk);
        rst = 1'b0;
        check_bit("usb_data_oe", usb_data_oe, 1'b0);
        check_bit("tio_trigger", tio_trigger, 1'b0);
        rand_byte(want);
        for (int i = 0; i < 8; i++) begin
            @(negedge usb_clk);
            tio_clkin = want[i];
            #1 check_bit("tio_clkout", tio_clkout, want[i]);
        end
        foreach (stim[i]) begin
            e = stim[i];
            case (e.op)
                op_sw: begin
                    @(negedge usb_clk);
                    {pushbutton, sw4, sw3, sw2, sw1} = e.data[4:0];
                end
                op_wr: bus_write(e.addr, e.data);
                op_rd: begin
                    bus_read(e.addr, got);
                    want = e.addr[10] ? shadow[e.addr[3:0]] : e.exp_byte;
                    check_byte("usb_data_out", got, want);
                end
                op_fill: begin
                    for (int j = 0; j < 16; j++) begin
                        rand_byte(want);
                        bus_write(e.addr + addr_w'(j), want);
                    end
                    for (int j = 0; j < 16; j++) begin
                        bus_read(e.addr + addr_w'(j), got);
                        check_byte("usb_data_out", got, shadow[j]);
                    end
                end
                op_led: begin
                    check_bit("led1", led1, shadow[0][2]);
                    check_bit("led2", led2, shadow[0][1]);
                    check_bit("led3", led3, shadow[0][0]);
                end
                op_trig: run_trigger();
            endcase
        end
        repeat (2) @(negedge usb_clk);
        if (u_cw305_top.u_checker.fired) begin
            $display("Bus checker assertion failed during the run");
            stop_run();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verification/cw305_checker.sv */
// Bus and trigger assertions
`timescale 1ns/1ps
`default_nettype none

module cw305_checker (
    input wire                      usb_clk,
    input wire                      rst,
    input wire cw305_pkg::usb_req_t req,  // Strobes from the bus FSM
    input wire                      usb_wrn,
    input wire                      usb_data_oe,
    input wire                      tio_trigger,
    input wire cw305_pkg::byte_t    pulse_len
);

    logic fired = 1'b0;  // Sticky

    a_strobe_excl: assert property (@(posedge usb_clk) disable iff (rst) !(req.rd && req.wr))
        else begin
            $error("rd and wr strobes high together");
            fired = 1'b1;
        end

    a_strobe_once: assert property (@(posedge usb_clk) disable iff (rst)
        (req.rd || req.wr) |=> !(req.rd || req.wr))
        else begin
            $error("request strobe longer than one cycle");
            fired = 1'b1;
        end

    a_oe_vs_wrn: assert property (@(posedge usb_clk) disable iff (rst) !(usb_data_oe && !usb_wrn))
        else begin
            $error("data_oe high during a write");
            fired = 1'b1;
        end

    // Length sampled on the load edge
    a_zero_len: assert property (@(posedge usb_clk) disable iff (rst)
        $rose(tio_trigger) |-> $past(pulse_len) != '0)
        else begin
            $error("tio_trigger pulse started with zero length");
            fired = 1'b1;
        end

endmodule

bind cw305_top cw305_checker u_checker (
    .usb_clk, .rst, .req, .usb_wrn, .usb_data_oe, .tio_trigger, .pulse_len
);

`default_nettype wire

/* hdl/cw305_top.sv */
// CW305 target top level
`timescale 1ns/1ps
`default_nettype none

module cw305_top (
    // Host bus
    input  wire                         usb_clk,
    input  wire                         rst,
    input  wire [cw305_pkg::addr_w-1:0] usb_addr,
    input  wire cw305_pkg::byte_t       usb_data_in,   // Pad input side
    output cw305_pkg::byte_t            usb_data_out,  // Pad output side
    output logic                        usb_data_oe,   // Pad drive enable
    input  wire                         usb_rdn,
    input  wire                         usb_wrn,
    input  wire                         usb_cen,       // Chip enable, not decoded
    input  wire                         usb_trigger,
    // Board I/O
    input  wire                         sw1,
    input  wire                         sw2,
    input  wire                         sw3,
    input  wire                         sw4,
    input  wire                         pushbutton,
    output logic                        led1,  // Red
    output logic                        led2,  // Green
    output logic                        led3,  // Blue
    input  wire                         pll_clk1,  // No second domain yet
    // 20-pin connector
    output logic                        tio_trigger,
    output logic                        tio_clkout,
    input  wire                         tio_clkin
);

    import cw305_pkg::*;

    usb_req_t          req;
    byte_t             rdata;
    byte_t             pulse_len;
    byte_t             pulse_count;
    switch_t           switches;
    logic [led_w-1:0]  leds;

    assign switches = '{pushbutton: pushbutton, sw4: sw4, sw3: sw3, sw2: sw2, sw1: sw1};

    usb_bus_fsm u_bus_fsm (
        .usb_clk  (usb_clk),
        .rst      (rst),
        .addr     (usb_addr),
        .data_in  (usb_data_in),
        .rdn      (usb_rdn),
        .wrn      (usb_wrn),
        .rdata    (rdata),
        .req      (req),
        .data_out (usb_data_out),
        .data_oe  (usb_data_oe)
    );

    usb_reg_file u_reg_file (
        .usb_clk     (usb_clk),
        .rst         (rst),
        .req         (req),
        .switches    (switches),
        .pulse_count (pulse_count),
        .rdata       (rdata),
        .leds        (leds),
        .pulse_len   (pulse_len)
    );

    trigger_timer u_trigger_timer (
        .usb_clk     (usb_clk),
        .rst         (rst),
        .usb_trigger (usb_trigger),
        .pulse_len   (pulse_len),
        .tio_trigger (tio_trigger),
        .pulse_count (pulse_count)
    );

    // Byte 0x400 is [x x x x x led1 led2 led3]
    assign led1 = leds[2];
    assign led2 = leds[1];
    assign led3 = leds[0];

    assign tio_clkout = tio_clkin;  // Straight pass-through

endmodule

`default_nettype wire

/* hdl/trigger_timer.sv */
// Trigger pulse timer
`timescale 1ns/1ps
`default_nettype none

module trigger_timer (
    input  wire                   usb_clk,
    input  wire                   rst,
    input  wire                   usb_trigger,  // Rising edge starts a pulse
    input  wire cw305_pkg::byte_t pulse_len,    // Pulse length in cycles
    output logic                  tio_trigger,
    output cw305_pkg::byte_t      pulse_count   // Wraps at 8 bits
);

    import cw305_pkg::*;

    logic  trig_q;  // Previous usb_trigger
    logic  rise;
    byte_t remain;  // Cycles left in current pulse

    assign rise = usb_trigger && !trig_q;

    always_ff @(posedge usb_clk) begin
        if (rst) begin
            trig_q      <= 1'b0;
            remain      <= '0;
            pulse_count <= '0;
        end else begin
            trig_q <= usb_trigger;
            if (remain == '0) begin
                // Idle, a zero length loads nothing
                if (rise) begin
                    remain <= pulse_len;
                end
            end else begin
                remain <= remain - 1'b1;  // Edges during pulse ignored
                if (remain == 8'd1) begin
                    pulse_count <= pulse_count + 1'b1;  // Pulse ends here
                end
            end
        end
    end

    assign tio_trigger = (remain != '0);

endmodule

`default_nettype wire

/* hdl/usb_reg_file.sv */
// Host register file
`timescale 1ns/1ps
`default_nettype none

module usb_reg_file (
    input  wire                           usb_clk,
    input  wire                           rst,
    input  wire cw305_pkg::usb_req_t      req,          // From bus FSM
    input  wire cw305_pkg::switch_t       switches,
    input  wire cw305_pkg::byte_t         pulse_count,  // Finished pulses
    output cw305_pkg::byte_t              rdata,
    output logic [cw305_pkg::led_w-1:0]   leds,
    output cw305_pkg::byte_t              pulse_len
);

    import cw305_pkg::*;

    byte_t in_mem [mem_depth];  // Input region storage
    byte_t out_byte;            // Selected output region byte

    // Input region writes, output region is read-only
    always_ff @(posedge usb_clk) begin
        if (rst) begin
            for (int i = 0; i < mem_depth; i++) begin
                in_mem[i] <= '0;
            end
        end else if (req.wr && req.region) begin
            in_mem[req.index] <= req.wdata;
        end
    end

    // Output region decode
    always_comb begin
        case (req.index)
            out_id:     out_byte = id_value;
            out_switch: out_byte = {{(data_w - $bits(switch_t)){1'b0}}, switches};
            out_count:  out_byte = pulse_count;
            default:    out_byte = '0;  // Unmapped reads as zero
        endcase
    end

    // Read data captured on the edge after rd, held until next read
    always_ff @(posedge usb_clk) begin
        if (req.rd) begin
            rdata <= req.region ? in_mem[req.index] : out_byte;
        end
    end

    assign leds      = in_mem[in_led][led_w-1:0];  // Byte 0 bits 2:0
    assign pulse_len = in_mem[in_pulse_len];

endmodule

`default_nettype wire

/* hdl/usb_bus_fsm.sv */
// Host bus access state machine
`timescale 1ns/1ps
`default_nettype none

module usb_bus_fsm (
    input  wire                      usb_clk,
    input  wire                      rst,
    input  wire [cw305_pkg::addr_w-1:0] addr,     // Host address
    input  wire cw305_pkg::byte_t    data_in,     // Host write data
    input  wire                      rdn,         // Active-low read level
    input  wire                      wrn,         // Active-low write level
    input  wire cw305_pkg::byte_t    rdata,       // Registered read data
    output cw305_pkg::usb_req_t      req,
    output cw305_pkg::byte_t         data_out,
    output logic                     data_oe
);

    import cw305_pkg::*;

    typedef enum logic [1:0] {
        idle,
        read_hold,   // Strobe sent, wait for rdn high
        write_hold   // Strobe sent, wait for wrn high
    } state_t;

    state_t state;

    always_ff @(posedge usb_clk) begin
        if (rst) begin
            state <= idle;
            req   <= '0;
        end else begin
            // Strobes last one cycle only
            req.rd <= 1'b0;
            req.wr <= 1'b0;
            case (state)
                idle: begin
                    if (!wrn) begin
                        state      <= write_hold;
                        req.wr     <= 1'b1;
                        req.region <= addr[region_bit];
                        req.index  <= addr[mem_w-1:0];  // Upper bits alias
                        req.wdata  <= data_in;
                    end else if (!rdn) begin
                        state      <= read_hold;
                        req.rd     <= 1'b1;
                        req.region <= addr[region_bit];
                        req.index  <= addr[mem_w-1:0];
                    end
                end
                read_hold: begin
                    if (rdn) begin
                        state <= idle;  // Releases data_oe on this edge
                    end
                end
                write_hold: begin
                    if (wrn) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Drive the pad only while a read is held
    assign data_oe  = (state == read_hold);
    assign data_out = (state == read_hold) ? rdata : '0;  // Valid from edge 1

endmodule

`default_nettype wire

/* hdl/cw305_pkg.sv */
// CW305 target shared definitions
`default_nettype none

package cw305_pkg;

    // Host bus geometry
    localparam int addr_w     = 21;  // Full host address width
    localparam int data_w     = 8;   // Byte-wide data bus
    localparam int mem_w      = 4;   // Decoded index bits per region
    localparam int mem_depth  = 2 ** mem_w;
    localparam int region_bit = 10;  // High selects input region
    localparam int led_w      = 3;

    // Identifier returned at output index 0
    localparam logic [data_w-1:0] id_value = 8'h2E;

    // Output region layout, read-only to host
    localparam logic [mem_w-1:0] out_id     = 4'd0;
    localparam logic [mem_w-1:0] out_switch = 4'd1;
    localparam logic [mem_w-1:0] out_count  = 4'd2;  // Finished trigger pulses

    // Input region layout, host writable
    localparam logic [mem_w-1:0] in_led       = 4'd0;  // LED bits 2:0
    localparam logic [mem_w-1:0] in_pulse_len = 4'd1;  // Trigger length in cycles

    typedef logic [data_w-1:0] byte_t;

    // One request per bus access
    typedef struct packed {
        logic             rd;      // Single-cycle read strobe
        logic             wr;      // Single-cycle write strobe
        logic             region;  // 1 = input region
        logic [mem_w-1:0] index;   // Byte within region
        byte_t            wdata;
    } usb_req_t;

    // Board switches, packed MSB first
    typedef struct packed {
        logic pushbutton;
        logic sw4;
        logic sw3;
        logic sw2;
        logic sw1;
    } switch_t;

endpackage

`default_nettype wire
